// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = mem_subsys_tb
FILELIST = all.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: all.f
+incdir+hw
hw/mem_pkg.sv
hw/mem_arbiter.sv
hw/line_mem.sv
hw/io_map.sv
hw/frame_fetch.sv
hw/pattern_check.sv
hw/mem_subsys_top.sv
dv/mem_subsys_properties.sv
dv/mem_subsys_tb.sv

// File: dv/mem_subsys_properties.sv
module mem_subsys_properties (
	input logic       clk_in,
	input logic       gl_rst,
	input logic [2:0] valid,
	input logic [2:0] ready,
	input logic       mem_wren,
	input logic       mem_rden,
	input logic       mem_wr_rdy
);

	int err_count = 0;

	////////////////////////////////////////////////////////////
	// Arbiter grant and memory strobe rules
	////////////////////////////////////////////////////////////
	one_ready: assert property (@(posedge clk_in) disable iff (gl_rst) $onehot0(ready))
	else begin
		err_count++;
		$error("More than one client got ready in the same cycle");
	end

	ready_valid: assert property (@(posedge clk_in) disable iff (gl_rst)
		(ready & ~valid) == 3'b000)
	else begin
		err_count++;
		$error("Ready given to a client without a valid request");
	end

	one_strobe: assert property (@(posedge clk_in) disable iff (gl_rst)
		!(mem_wren && mem_rden))
	else begin
		err_count++;
		$error("Write and read enable high together");
	end

	// Write ready follows the enable by one cycle
	wr_latency: assert property (@(posedge clk_in) disable iff (gl_rst)
		mem_wren |=> mem_wr_rdy)
	else begin
		err_count++;
		$error("Write ready missing one cycle after write enable");
	end

	wr_origin: assert property (@(posedge clk_in) disable iff (gl_rst)
		mem_wr_rdy |-> $past(mem_wren))
	else begin
		err_count++;
		$error("Write ready without a write enable one cycle before");
	end

endmodule

bind mem_arbiter mem_subsys_properties i_mem_subsys_properties (
	.clk_in     (clk_in),
	.gl_rst     (gl_rst),
	.valid      (valid),
	.ready      (ready),
	.mem_wren   (mem_wren),
	.mem_rden   (mem_rden),
	.mem_wr_rdy (mem_wr_rdy)
);

// File: dv/mem_subsys_tb.sv
`include "mem_macros.svh"

module mem_subsys_tb;
	import mem_pkg::*;

	logic      clk_in;
	logic      gl_rst;
	host_req_t host_req;
	logic      host_valid;
	logic      host_ready;
	line_t     host_rdata;
	line_t     pix_line;
	logic      pix_valid;
	logic      mem_error;

	// Reference copy of the line memory
	line_t      model [2**`LINE_ADDR_BITS];
	logic       check_ran;
	logic       host_chk;
	line_t      host_exp;
	string      host_what;
	line_addr_t pix_base;
	int         pix_epoch;
	int         seen_epoch = 0;
	int         pix_idx = 0;
	int         pix_count = 0;
	int         ops_issued;

	mem_subsys_top i_mem_subsys_top (.*);

	initial begin
		clk_in = 1'b0;
		forever #4 clk_in = ~clk_in;
	end

	// Expected line, check region follows the pattern rule once a check has run
	function automatic line_t ref_line(input int line);
		line_t val;
		int    l;
		int    i;
		l = line % (2**`LINE_ADDR_BITS);
		i = l - `CHECK_BASE;
		if (check_ran && i >= 0 && i < `CHECK_LINES) begin
			for (int w = 0; w < `LINE_BITS / 32; w++)
				val[w*32 +: 32] = `CHECK_SEED + i * 8 + w;
			return val;
		end
		return model[line_addr_t'(l)];
	endfunction

	function automatic line_t rand_line();
		line_t val;
		for (int w = 0; w < `LINE_BITS / 32; w++)
			val[w*32 +: 32] = $urandom;
		return val;
	endfunction

	function automatic addr_t reg_addr(input reg_sel_t sel);
		return (addr_t'(1) << `REG_SPACE_BIT) | addr_t'(sel);
	endfunction

	task automatic fail_stop(input string what);
		$display("%s", what);
		$display("Simulation failed");
		$fatal(1, "Run stopped at first error");
	endtask

	////////////////////////////////////////////////////////////
	// Host port transfers
	////////////////////////////////////////////////////////////
	task automatic host_xfer(input addr_t addr, input logic rw, input line_t wdata,
			input logic chk, input line_t exp, input string what, output line_t rdata);
		@(negedge clk_in);
		host_req.addr = addr;
		host_req.rw = rw;
		host_req.wdata = wdata;
		host_chk = chk;
		host_exp = exp;
		host_what = what;
		host_valid = 1'b1;
		ops_issued++;
		// Request held through the ready cycle
		do
			@(negedge clk_in);
		while (!host_ready);
		rdata = host_rdata;
		// Transfer completes on the rising edge that ends the ready cycle
		@(negedge clk_in);
		host_valid = 1'b0;
	endtask

	task automatic mem_write(input int line, input line_t data);
		line_t unused;
		host_xfer(addr_t'(line), 1'b1, data, 1'b0, '0, "", unused);
		model[line_addr_t'(line)] = data;
	endtask

	task automatic mem_read(input int line);
		line_t unused;
		host_xfer(addr_t'(line), 1'b0, '0, 1'b1, ref_line(line),
			$sformatf("host_rdata line %0d", line), unused);
	endtask

	task automatic reg_write(input reg_sel_t sel, input int value);
		line_t unused;
		host_xfer(reg_addr(sel), 1'b1, line_t'(value), 1'b0, '0, "", unused);
	endtask

	task automatic reg_read(input reg_sel_t sel, input int value);
		line_t unused;
		host_xfer(reg_addr(sel), 1'b0, '0, 1'b1, line_t'(value),
			$sformatf("host_rdata reg %s", sel.name()), unused);
	endtask

	// Poll until done, then expect done set with error clear
	task automatic check_wait();
		line_t data;
		int    polls;
		polls = 0;
		do begin
			host_xfer(reg_addr(REG_CHECK), 1'b0, '0, 1'b0, '0, "", data);
			polls++;
			assert (polls < 500)
			else fail_stop("Self-check never reported done");
		end while (!data[0]);
		check_ran = 1'b1;
		reg_read(REG_CHECK, 1);
	endtask

	task automatic display_start(input int start);
		reg_write(REG_START, start);
		pix_base = line_addr_t'(start);
		pix_epoch++;
		reg_write(REG_DISPLAY, 1);
	endtask

	// Long enough for the last fetch to drain
	task automatic display_stop();
		reg_write(REG_DISPLAY, 0);
		repeat (100) @(negedge clk_in);
	endtask

	task automatic wait_pixels(input int n);
		int base;
		base = pix_count;
		while (pix_count < base + n)
			@(negedge clk_in);
	endtask

	////////////////////////////////////////////////////////////
	// Compare process
	////////////////////////////////////////////////////////////
	always @(negedge clk_in) begin
		if (pix_epoch != seen_epoch) begin
			seen_epoch = pix_epoch;
			pix_idx = 0;
		end
		if (!gl_rst) begin
			assert (!mem_error)
			else fail_stop($sformatf("Self-check error flag set at time %0t", $time));
			assert (i_mem_subsys_top.i_mem_arbiter.i_mem_subsys_properties.err_count == 0)
			else fail_stop("Arbiter property check failed");
			if (host_ready && host_chk) begin
				assert (host_rdata === host_exp)
				else fail_stop($sformatf("MISMATCH time %0t %s expected %h actual %h",
					$time, host_what, host_exp, host_rdata));
			end
			if (pix_valid) begin
				assert (pix_line === ref_line(pix_base + pix_idx))
				else fail_stop($sformatf("MISMATCH time %0t pix_line expected %h actual %h",
					$time, ref_line(pix_base + pix_idx), pix_line));
				pix_idx = (pix_idx + 1) % `FRAME_LINES;
				pix_count++;
			end
		end
	end

	// Watchdog, budget grows with each issued host operation
	initial begin
		int cycles;
		cycles = 0;
		forever begin
			@(posedge clk_in);
			cycles++;
			assert (cycles <= 200 * ops_issued + 2000)
			else fail_stop("Timeout, the DUT stopped making progress");
		end
	end

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////
	initial begin
		int line;
		int start;
		void'($urandom(62));
		gl_rst = 1'b1;
		host_valid = 1'b0;
		host_req = '0;
		host_chk = 1'b0;
		host_exp = '0;
		host_what = "";
		check_ran = 1'b0;
		pix_base = '0;
		pix_epoch = 0;
		ops_issued = 0;
		repeat (16) @(negedge clk_in);
		gl_rst = 1'b0;

		// Fill all lines outside the check region, then random rewrites
		for (int l = 0; l < 64; l++) begin
			if (l < `CHECK_BASE || l >= `CHECK_BASE + `CHECK_LINES)
				mem_write(l, rand_line());
		end
		for (int n = 0; n < 40; n++)
			mem_write($urandom_range(47, 0), rand_line());
		for (int l = 0; l < 64; l++) begin
			if (l < `CHECK_BASE || l >= `CHECK_BASE + `CHECK_LINES)
				mem_read(l);
		end

		// Register readback
		start = $urandom_range(63, 0);
		reg_write(REG_START, start);
		reg_write(REG_DISPLAY, 0);
		reg_read(REG_START, start);
		reg_read(REG_DISPLAY, 0);

		// Frame that wraps past the top of memory
		display_start(61);
		reg_read(REG_DISPLAY, 1);
		wait_pixels(12);
		display_stop();

		// Self-check alone
		reg_write(REG_CHECK, 1);
		check_wait();
		for (int l = `CHECK_BASE; l < `CHECK_BASE + `CHECK_LINES; l++)
			mem_read(l);

		// Display, self-check and host traffic together
		start = $urandom_range(44, 0);
		display_start(start);
		reg_write(REG_CHECK, 1);
		for (int n = 0; n < 60; n++) begin
			if ($urandom_range(1, 0) == 1) begin
				do
					line = $urandom_range(47, 0);
				while (line >= start && line < start + `FRAME_LINES);
				mem_write(line, rand_line());
			end else begin
				mem_read($urandom_range(55, 0));
			end
		end
		check_wait();
		wait_pixels(8);
		display_stop();
		for (int l = 0; l < `CHECK_BASE + `CHECK_LINES; l++)
			mem_read(l);

		$display("Simulation passed");
		$finish;
	end

endmodule

// File: hw/frame_fetch.sv
`include "mem_macros.svh"

module frame_fetch (
	input  logic                clk_in,
	input  logic                gl_rst,
	input  logic                display_on,
	input  mem_pkg::line_addr_t start_line,
	output mem_pkg::mem_req_t   req,
	output logic                valid,
	input  logic                ready,
	input  mem_pkg::line_t      rdata,
	output mem_pkg::line_t      pix_line,
	output logic                pix_valid
);
	import mem_pkg::*;

	localparam int IDX_BITS = $clog2(`FRAME_LINES);

	fetch_state_t        state;
	logic [IDX_BITS-1:0] idx;
	line_addr_t          fetch_addr;

	////////////////////////////////////////////////////////////
	// Fetch sequencer
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_in) begin
		if (gl_rst) begin
			state <= FETCH_OFF;
			idx <= '0;
			pix_valid <= 1'b0;
		end else begin
			pix_valid <= 1'b0;
			case (state)
				FETCH_OFF: begin
					idx <= '0;
					if (display_on)
						state <= FETCH_REQ;
				end
				// Address wraps at the end of the line memory
				FETCH_REQ: begin
					fetch_addr <= start_line + line_addr_t'(idx);
					state <= FETCH_WAIT;
				end
				FETCH_WAIT: begin
					if (ready) begin
						pix_valid <= 1'b1;
						if (idx == IDX_BITS'(`FRAME_LINES - 1))
							idx <= '0;
						else
							idx <= idx + 1'b1;
						if (display_on)
							state <= FETCH_REQ;
						else
							state <= FETCH_OFF;
					end
				end
				default: state <= FETCH_OFF;
			endcase
		end
	end

	always_ff @(posedge clk_in) begin
		if (state == FETCH_WAIT && ready)
			pix_line <= rdata;
	end

	assign valid = (state == FETCH_WAIT);
	assign req.addr = `ADDR_BITS'(fetch_addr);
	assign req.rw = 1'b0;
	assign req.wdata = '0;

endmodule

// File: hw/io_map.sv
`include "mem_macros.svh"

module io_map (
	input  logic                clk_in,
	input  logic                gl_rst,
	input  mem_pkg::host_req_t  host_req,
	input  logic                host_valid,
	output logic                host_ready,
	output mem_pkg::line_t      host_rdata,
	output mem_pkg::mem_req_t   mem_req,
	output logic                mem_valid,
	input  logic                mem_ready,
	input  mem_pkg::line_t      mem_rdata,
	output mem_pkg::line_addr_t start_line,
	output logic                display_on,
	output logic                check_start,
	input  logic                check_done,
	input  logic                check_error
);
	import mem_pkg::*;

	logic                       reg_space;
	logic                       reg_hit;
	logic                       reg_ack;
	reg_sel_t                   reg_sel;
	logic [`LINE_ADDR_BITS-1:0] reg_rdata;

	assign reg_space = host_req.addr[`REG_SPACE_BIT];
	assign reg_sel = reg_sel_t'(host_req.addr[1:0]);
	// New register access, the acknowledged one is still on the bus
	assign reg_hit = host_valid && reg_space && !reg_ack;

	// Memory accesses pass straight to the arbiter
	assign mem_req.addr = host_req.addr;
	assign mem_req.rw = host_req.rw;
	assign mem_req.wdata = host_req.wdata;
	assign mem_valid = host_valid && !reg_space;

	////////////////////////////////////////////////////////////
	// Register map
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_in) begin
		if (gl_rst) begin
			reg_ack <= 1'b0;
			start_line <= '0;
			display_on <= 1'b0;
			check_start <= 1'b0;
		end else begin
			reg_ack <= reg_hit;
			check_start <= 1'b0;
			if (reg_hit && host_req.rw) begin
				case (reg_sel)
					REG_START:   start_line <= host_req.wdata[`LINE_ADDR_BITS-1:0];
					REG_DISPLAY: display_on <= host_req.wdata[0];
					REG_CHECK:   check_start <= host_req.wdata[0];
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk_in) begin
		if (reg_hit) begin
			case (reg_sel)
				REG_START:   reg_rdata <= start_line;
				REG_DISPLAY: reg_rdata <= `LINE_ADDR_BITS'(display_on);
				REG_CHECK:   reg_rdata <= `LINE_ADDR_BITS'({check_error, check_done});
				default:     reg_rdata <= '0;
			endcase
		end
	end

	assign host_ready = reg_ack | mem_ready;
	assign host_rdata = reg_ack ? line_t'(reg_rdata) : mem_rdata;

endmodule

// File: hw/line_mem.sv
`include "mem_macros.svh"

module line_mem (
	input  logic                clk_in,
	input  logic                gl_rst,
	input  logic                wren,
	input  logic                rden,
	input  mem_pkg::line_addr_t addr,
	input  mem_pkg::line_t      wdata,
	output logic                wr_rdy,
	output logic                rd_valid,
	output mem_pkg::line_t      rdata
);
	import mem_pkg::*;

	line_t                mem_array [2**`LINE_ADDR_BITS];
	line_t                data_pipe [`READ_LAT];
	logic [`READ_LAT-1:0] valid_pipe;

	////////////////////////////////////////////////////////////
	// Storage and read data delay
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_in) begin
		if (wren)
			mem_array[addr] <= wdata;
		if (rden)
			data_pipe[0] <= mem_array[addr];
		for (int i = 1; i < `READ_LAT; i++) begin
			data_pipe[i] <= data_pipe[i-1];
		end
	end

	// Strobes, write ready one cycle after the enable
	always_ff @(posedge clk_in) begin
		if (gl_rst) begin
			wr_rdy <= 1'b0;
			valid_pipe <= '0;
		end else begin
			wr_rdy <= wren;
			valid_pipe <= (valid_pipe << 1) | `READ_LAT'(rden);
		end
	end

	assign rd_valid = valid_pipe[`READ_LAT-1];
	assign rdata = data_pipe[`READ_LAT-1];

endmodule

// File: hw/mem_arbiter.sv
`include "mem_macros.svh"

module mem_arbiter (
	input  logic                    clk_in,
	input  logic                    gl_rst,
	input  mem_pkg::mem_req_t [2:0] req,
	input  logic [2:0]              valid,
	output logic [2:0]              ready,
	output mem_pkg::line_t          rdata,
	output logic                    mem_wren,
	output logic                    mem_rden,
	output mem_pkg::line_addr_t     mem_addr,
	output mem_pkg::line_t          mem_wdata,
	input  logic                    mem_wr_rdy,
	input  logic                    mem_rd_valid,
	input  mem_pkg::line_t          mem_rdata
);
	import mem_pkg::*;

	arb_state_t state;
	logic [1:0] grant;
	logic [1:0] next_grant;
	logic       any_valid;
	logic       cur_rw;
	logic       done;

	// Round robin, nearest valid client after the last grant wins
	always_comb begin
		next_grant = grant;
		any_valid = 1'b0;
		for (int k = 3; k >= 1; k--) begin
			if (valid[(32'(grant) + k) % 3]) begin
				next_grant = 2'((32'(grant) + k) % 3);
				any_valid = 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Control FSM
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_in) begin
		if (gl_rst) begin
			state <= ARB_IDLE;
			grant <= 2'd2;
			mem_wren <= 1'b0;
			mem_rden <= 1'b0;
		end else begin
			mem_wren <= 1'b0;
			mem_rden <= 1'b0;
			case (state)
				ARB_IDLE: begin
					if (any_valid) begin
						grant <= next_grant;
						state <= ARB_ISSUE;
					end
				end
				ARB_ISSUE: begin
					mem_wren <= cur_rw;
					mem_rden <= !cur_rw;
					if (cur_rw)
						state <= ARB_WAIT_WR;
					else
						state <= ARB_WAIT_RD;
				end
				ARB_WAIT_WR: if (mem_wr_rdy) state <= ARB_IDLE;
				ARB_WAIT_RD: if (mem_rd_valid) state <= ARB_IDLE;
				default: state <= ARB_IDLE;
			endcase
		end
	end

	// Granted request, held until the access completes
	always_ff @(posedge clk_in) begin
		if (state == ARB_IDLE && any_valid) begin
			cur_rw <= req[next_grant].rw;
			mem_addr <= req[next_grant].addr[`LINE_ADDR_BITS-1:0];
			mem_wdata <= req[next_grant].wdata;
		end
	end

	assign done = (state == ARB_WAIT_WR && mem_wr_rdy) ||
		(state == ARB_WAIT_RD && mem_rd_valid);

	// Completion goes to the granted client only
	always_comb begin
		ready = '0;
		ready[grant] = done;
	end

	assign rdata = mem_rdata;

endmodule

// File: hw/mem_macros.svh
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// Line and address widths
`define LINE_BITS      256
`define ADDR_BITS      28
`define LINE_ADDR_BITS 6
`define REG_SPACE_BIT  27

// Memory read latency in cycles
`define READ_LAT       2

// Display frame and self-check region
`define FRAME_LINES    4
`define CHECK_BASE     48
`define CHECK_LINES    8
`define CHECK_SEED     32'hC0DE0000

`endif

// File: hw/mem_pkg.sv
`include "mem_macros.svh"

package mem_pkg;

	typedef logic [`LINE_BITS-1:0]      line_t;
	typedef logic [`ADDR_BITS-1:0]      addr_t;
	typedef logic [`LINE_ADDR_BITS-1:0] line_addr_t;

	// Client request toward the arbiter, rw high for a write
	typedef struct packed {
		addr_t addr;
		logic  rw;
		line_t wdata;
	} mem_req_t;

	// Host request, address may also point into register space
	typedef struct packed {
		addr_t addr;
		logic  rw;
		line_t wdata;
	} host_req_t;

	typedef enum logic [1:0] {ARB_IDLE, ARB_ISSUE, ARB_WAIT_WR, ARB_WAIT_RD} arb_state_t;

	typedef enum logic [1:0] {FETCH_OFF, FETCH_REQ, FETCH_WAIT} fetch_state_t;

	typedef enum logic [1:0] {CHK_IDLE, CHK_WRITE, CHK_READ, CHK_DONE} check_state_t;

	typedef enum logic [1:0] {
		REG_START   = 2'd0,
		REG_DISPLAY = 2'd1,
		REG_CHECK   = 2'd2
	} reg_sel_t;

endpackage

// File: hw/mem_subsys_top.sv
module mem_subsys_top (
	input  logic               clk_in,
	input  logic               gl_rst,
	input  mem_pkg::host_req_t host_req,
	input  logic               host_valid,
	output logic               host_ready,
	output mem_pkg::line_t     host_rdata,
	output mem_pkg::line_t     pix_line,
	output logic               pix_valid,
	output logic               mem_error
);
	import mem_pkg::*;

	// Clients in arbiter order are host, display, check
	mem_req_t [2:0] cli_req;
	logic [2:0]     cli_valid;
	logic [2:0]     cli_ready;
	line_t          cli_rdata;

	logic           mem_wren;
	logic           mem_rden;
	line_addr_t     mem_addr;
	line_t          mem_wdata;
	logic           mem_wr_rdy;
	logic           mem_rd_valid;
	line_t          mem_rdata;

	line_addr_t     start_line;
	logic           display_on;
	logic           check_start;
	logic           check_done;

	mem_arbiter i_mem_arbiter (
		.clk_in       (clk_in),
		.gl_rst       (gl_rst),
		.req          (cli_req),
		.valid        (cli_valid),
		.ready        (cli_ready),
		.rdata        (cli_rdata),
		.mem_wren     (mem_wren),
		.mem_rden     (mem_rden),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata),
		.mem_wr_rdy   (mem_wr_rdy),
		.mem_rd_valid (mem_rd_valid),
		.mem_rdata    (mem_rdata)
	);

	line_mem i_line_mem (
		.clk_in   (clk_in),
		.gl_rst   (gl_rst),
		.wren     (mem_wren),
		.rden     (mem_rden),
		.addr     (mem_addr),
		.wdata    (mem_wdata),
		.wr_rdy   (mem_wr_rdy),
		.rd_valid (mem_rd_valid),
		.rdata    (mem_rdata)
	);

	io_map i_io_map (
		.clk_in      (clk_in),
		.gl_rst      (gl_rst),
		.host_req    (host_req),
		.host_valid  (host_valid),
		.host_ready  (host_ready),
		.host_rdata  (host_rdata),
		.mem_req     (cli_req[0]),
		.mem_valid   (cli_valid[0]),
		.mem_ready   (cli_ready[0]),
		.mem_rdata   (cli_rdata),
		.start_line  (start_line),
		.display_on  (display_on),
		.check_start (check_start),
		.check_done  (check_done),
		.check_error (mem_error)
	);

	frame_fetch i_frame_fetch (
		.clk_in     (clk_in),
		.gl_rst     (gl_rst),
		.display_on (display_on),
		.start_line (start_line),
		.req        (cli_req[1]),
		.valid      (cli_valid[1]),
		.ready      (cli_ready[1]),
		.rdata      (cli_rdata),
		.pix_line   (pix_line),
		.pix_valid  (pix_valid)
	);

	pattern_check i_pattern_check (
		.clk_in      (clk_in),
		.gl_rst      (gl_rst),
		.check_start (check_start),
		.req         (cli_req[2]),
		.valid       (cli_valid[2]),
		.ready       (cli_ready[2]),
		.rdata       (cli_rdata),
		.check_done  (check_done),
		.check_error (mem_error)
	);

endmodule

// File: hw/pattern_check.sv
`include "mem_macros.svh"

module pattern_check (
	input  logic              clk_in,
	input  logic              gl_rst,
	input  logic              check_start,
	output mem_pkg::mem_req_t req,
	output logic              valid,
	input  logic              ready,
	input  mem_pkg::line_t    rdata,
	output logic              check_done,
	output logic              check_error
);
	import mem_pkg::*;

	localparam int IDX_BITS = $clog2(`CHECK_LINES);

	check_state_t        state;
	logic [IDX_BITS-1:0] idx;
	logic                last;
	line_t               expect_line;

	// Word w of line i holds seed + i*8 + w
	function automatic line_t pattern(input logic [IDX_BITS-1:0] i);
		line_t val;
		val = '0;
		for (int w = 0; w < `LINE_BITS / 32; w++) begin
			val[w*32 +: 32] = `CHECK_SEED + 32'(i) * 32'd8 + 32'(w);
		end
		return val;
	endfunction

	assign expect_line = pattern(idx);
	assign last = (idx == IDX_BITS'(`CHECK_LINES - 1));

	////////////////////////////////////////////////////////////
	// Write pass, then read back pass
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_in) begin
		if (gl_rst) begin
			state <= CHK_IDLE;
			idx <= '0;
			check_done <= 1'b0;
			check_error <= 1'b0;
		end else begin
			case (state)
				CHK_IDLE, CHK_DONE: begin
					if (check_start) begin
						check_done <= 1'b0;
						idx <= '0;
						state <= CHK_WRITE;
					end
				end
				CHK_WRITE: begin
					if (ready) begin
						idx <= last ? '0 : idx + 1'b1;
						if (last)
							state <= CHK_READ;
					end
				end
				CHK_READ: begin
					if (ready) begin
						// Sticky until reset
						if (rdata != expect_line)
							check_error <= 1'b1;
						idx <= idx + 1'b1;
						if (last) begin
							check_done <= 1'b1;
							state <= CHK_DONE;
						end
					end
				end
				default: state <= CHK_IDLE;
			endcase
		end
	end

	assign valid = (state == CHK_WRITE) || (state == CHK_READ);
	assign req.addr = `ADDR_BITS'(`CHECK_BASE + 32'(idx));
	assign req.rw = (state == CHK_WRITE);
	assign req.wdata = expect_line;

endmodule
